// ==== rtl/hps_settings.svh ====
// widths and limits shared by the host command port
// include this wherever a port or package needs one of the sizes

`ifndef HPS_SETTINGS_SVH
`define HPS_SETTINGS_SVH

// host bus word, one per io_strobe
`define HPS_WORD_W 16

// word counter, also the config string address
`define HPS_WCNT_W 10

// byte lanes on the config string and the download bus
`define HPS_BYTE_W 8

`define HPS_JOY_W 32
`define HPS_STATUS_W 64
`define HPS_STSET_W 4
`define HPS_IOADDR_W 27

`endif

// ==== rtl/hps_cmd_pkg.sv ====
// host protocol types: command codes and the per-word context seen by the executors
// import into any block that decodes or consumes host words

`include "hps_settings.svh"

package hps_cmd_pkg;

	// command codes, first word of each frame
	typedef enum logic [`HPS_WORD_W-1:0] {
		CMD_CFG      = 16'h0001,
		CMD_JOY0     = 16'h0002,
		CMD_JOY1     = 16'h0003,
		CMD_CFGSTR   = 16'h0014,
		CMD_STATUS   = 16'h001E,
		CMD_STSET    = 16'h0029,
		CMD_MENUMASK = 16'h002E,
		CMD_FILE_TX  = 16'h0053,
		CMD_FILE_DAT = 16'h0054,
		CMD_FILE_IDX = 16'h0055
	} hps_cmd_e;

	//////////////////////////////////////////////////
	// context for one data word
	//////////////////////////////////////////////////

	typedef struct packed {
		// one cycle per data word
		logic                    valid;
		hps_cmd_e                cmd;
		// first data word is 1
		logic [`HPS_WCNT_W-1:0] index;
		logic [`HPS_WORD_W-1:0] data;
		// enable still high
		logic                    open;
	} hps_word_t;

endpackage

// ==== rtl/hps_core_pkg.sv ====
// core-side types: joysticks, status, config word and the download bus
// import into blocks that face the game core

`include "hps_settings.svh"

package hps_core_pkg;

	typedef logic [`HPS_JOY_W-1:0]    hps_joy_t;
	typedef logic [`HPS_STATUS_W-1:0] hps_status_t;

	// config word as sent by the host, unused bits are kept for the frame layout
	typedef struct packed {
		logic [4:0] rsvd_15_11;
		logic       direct_video;
		logic [4:0] rsvd_9_5;
		logic       forced_scandoubler;
		logic [1:0] rsvd_3_2;
		logic [1:0] buttons;
	} hps_cfg_t;

	// status-set request, counter plus the last captured value
	typedef struct packed {
		logic [`HPS_STSET_W-1:0] cnt;
		hps_status_t             status_in;
	} hps_stset_t;

	//////////////////////////////////////////////////
	// file download bus
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                      download;
		logic                      wr;
		logic [`HPS_WORD_W-1:0]   index;
		logic [`HPS_IOADDR_W-1:0] addr;
		logic [`HPS_BYTE_W-1:0]   dout;
	} ioctl_t;

endpackage

// ==== rtl/hps_cmd_decode.sv ====
// frames one host channel and turns each data strobe into a context pulse
// one instance per enable line, both share io_strobe and io_din

`timescale 1ns/1ps
`include "hps_settings.svh"

module hps_cmd_decode
	import hps_cmd_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  logic                   frame_en,
	input  logic                   io_strobe,
	input  logic [`HPS_WORD_W-1:0] io_din,
	output hps_word_t              word
);

	logic                   has_cmd;
	hps_cmd_e               cmd_q;
	// number of the next data word, sticks at all ones
	logic [`HPS_WCNT_W-1:0] cnt;
	logic [`HPS_WCNT_W-1:0] idx_q;
	logic [`HPS_WORD_W-1:0] data_q;
	logic                   valid_q;
	logic                   open_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			has_cmd <= 1'b0;
			cmd_q   <= hps_cmd_e'('0);
			cnt     <= '0;
			idx_q   <= '0;
			valid_q <= 1'b0;
			open_q  <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			open_q  <= frame_en;
			if (!frame_en) begin
				// frame closed, wait for the next command
				has_cmd <= 1'b0;
				cnt     <= '0;
				idx_q   <= '0;
			end else if (io_strobe) begin
				if (!has_cmd) begin
					cmd_q   <= hps_cmd_e'(io_din);
					has_cmd <= 1'b1;
					cnt     <= `HPS_WCNT_W'(1);
				end else begin
					valid_q <= 1'b1;
					idx_q   <= cnt;
					if (~&cnt) begin
						cnt <= cnt + 1'b1;
					end
				end
			end
		end
	end

	// word payload follows the bus on every strobe
	always_ff @(posedge clk_sys) begin
		if (io_strobe) begin
			data_q <= io_din;
		end
	end

	assign word = '{
		valid: valid_q,
		cmd:   cmd_q,
		index: idx_q,
		data:  data_q,
		open:  open_q
	};

endmodule

// ==== rtl/hps_user_regs.sv ====
// register commands from the host: config word, joysticks, status
// also tracks status-set requests raised by the core

`timescale 1ns/1ps
`include "hps_settings.svh"

module hps_user_regs
	import hps_cmd_pkg::*;
	import hps_core_pkg::*;
(
	input  logic        clk_sys,
	input  logic        rst,
	input  hps_word_t   word,
	input  logic        status_set,
	input  hps_status_t status_in,
	output hps_cfg_t    cfg,
	output hps_joy_t    joystick_0,
	output hps_joy_t    joystick_1,
	output hps_status_t status,
	output hps_stset_t  stset
);

	logic                    status_set_q;
	logic                    set_rise;
	logic [`HPS_STSET_W-1:0] stset_cnt;
	hps_status_t             status_req;

	// joystick arrives as low word then high word
	function automatic hps_joy_t joy_update(
		input hps_joy_t               joy,
		input logic [`HPS_WCNT_W-1:0] idx,
		input logic [`HPS_WORD_W-1:0] d
	);
		hps_joy_t r;
		r = joy;
		if (idx == `HPS_WCNT_W'(1)) begin
			r[`HPS_WORD_W-1:0] = d;
		end else if (idx == `HPS_WCNT_W'(2)) begin
			r[`HPS_JOY_W-1:`HPS_WORD_W] = d;
		end
		return r;
	endfunction

	assign set_rise = status_set & ~status_set_q;

	//////////////////////////////////////////////////
	// host writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word.valid) begin
			case (word.cmd)
				CMD_CFG:  cfg <= hps_cfg_t'(word.data);
				CMD_JOY0: joystick_0 <= joy_update(joystick_0, word.index, word.data);
				CMD_JOY1: joystick_1 <= joy_update(joystick_1, word.index, word.data);
				CMD_STATUS: begin
					// least significant word first
					case (word.index)
						`HPS_WCNT_W'(1): status[15:0]  <= word.data;
						`HPS_WCNT_W'(2): status[31:16] <= word.data;
						`HPS_WCNT_W'(3): status[47:32] <= word.data;
						`HPS_WCNT_W'(4): status[63:48] <= word.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// status-set request from the core
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			status_set_q <= 1'b0;
			stset_cnt    <= '0;
		end else begin
			status_set_q <= status_set;
			if (set_rise) begin
				stset_cnt <= stset_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (set_rise) begin
			status_req <= status_in;
		end
	end

	assign stset = '{cnt: stset_cnt, status_in: status_req};

endmodule

// ==== rtl/hps_file_loader.sv ====
// file download channel: index, start/stop and byte writes to the core
// the host paces data words against ioctl_wait

`timescale 1ns/1ps
`include "hps_settings.svh"

module hps_file_loader
	import hps_cmd_pkg::*;
	import hps_core_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst,
	input  hps_word_t word,
	output ioctl_t    ioctl
);

	localparam int ADDR_HI_W = `HPS_IOADDR_W - `HPS_WORD_W;

	logic                      download_q;
	logic                      wr_q;
	logic [`HPS_WORD_W-1:0]   index_q;
	// address presented with the write pulse
	logic [`HPS_IOADDR_W-1:0] addr_q;
	// address of the next byte
	logic [`HPS_IOADDR_W-1:0] next_addr;
	logic [`HPS_BYTE_W-1:0]   dout_q;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			download_q <= 1'b0;
			wr_q       <= 1'b0;
			index_q    <= '0;
		end else begin
			wr_q <= 1'b0;
			if (word.valid) begin
				case (word.cmd)
					CMD_FILE_IDX: index_q <= word.data;
					CMD_FILE_TX: begin
						if (word.index == `HPS_WCNT_W'(1)) begin
							download_q <= |word.data[`HPS_BYTE_W-1:0];
						end
					end
					CMD_FILE_DAT: begin
						if (download_q) begin
							wr_q <= 1'b1;
						end
					end
					default: ;
				endcase
			end
		end
	end

	//////////////////////////////////////////////////
	// address and data path
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (word.valid) begin
			case (word.cmd)
				CMD_FILE_TX: begin
					case (word.index)
						`HPS_WCNT_W'(1): begin
							if (|word.data[`HPS_BYTE_W-1:0]) begin
								next_addr <= '0;
							end else if (download_q) begin
								// stop leaves the final length on the bus
								addr_q <= next_addr;
							end
						end
						`HPS_WCNT_W'(2): begin
							addr_q[`HPS_WORD_W-1:0]    <= word.data;
							next_addr[`HPS_WORD_W-1:0] <= word.data;
						end
						`HPS_WCNT_W'(3): begin
							addr_q[`HPS_IOADDR_W-1:`HPS_WORD_W]    <= word.data[ADDR_HI_W-1:0];
							next_addr[`HPS_IOADDR_W-1:`HPS_WORD_W] <= word.data[ADDR_HI_W-1:0];
						end
						default: ;
					endcase
				end
				CMD_FILE_DAT: begin
					if (download_q) begin
						addr_q    <= next_addr;
						dout_q    <= word.data[`HPS_BYTE_W-1:0];
						next_addr <= next_addr + 1'b1;
					end
				end
				default: ;
			endcase
		end
	end

	assign ioctl = '{
		download: download_q,
		wr:       wr_q,
		index:    index_q,
		addr:     addr_q,
		dout:     dout_q
	};

endmodule

// ==== rtl/hps_reply_mux.sv ====
// registered reply word for host read commands
// a reply holds until the next data word and clears when the frame closes

`timescale 1ns/1ps
`include "hps_settings.svh"

module hps_reply_mux
	import hps_cmd_pkg::*;
	import hps_core_pkg::*;
(
	input  logic                   clk_sys,
	input  logic                   rst,
	input  hps_word_t              word,
	input  hps_stset_t             stset,
	input  logic [`HPS_WORD_W-1:0] status_menumask,
	input  logic [`HPS_BYTE_W-1:0] cfg_dout,
	output logic [`HPS_WORD_W-1:0] io_dout
);

	always_ff @(posedge clk_sys) begin
		if (rst || !word.open) begin
			io_dout <= '0;
		end else if (word.valid) begin
			io_dout <= '0;
			case (word.cmd)
				CMD_STSET: begin
					case (word.index)
						// marker nibble plus request count
						`HPS_WCNT_W'(1): io_dout <= {8'h00, 4'hA, stset.cnt};
						`HPS_WCNT_W'(2): io_dout <= stset.status_in[15:0];
						`HPS_WCNT_W'(3): io_dout <= stset.status_in[31:16];
						`HPS_WCNT_W'(4): io_dout <= stset.status_in[47:32];
						`HPS_WCNT_W'(5): io_dout <= stset.status_in[63:48];
						default: ;
					endcase
				end
				CMD_MENUMASK: begin
					if (word.index == `HPS_WCNT_W'(1)) begin
						io_dout <= status_menumask;
					end
				end
				CMD_CFGSTR: io_dout <= {{(`HPS_WORD_W-`HPS_BYTE_W){1'b0}}, cfg_dout};
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/hps_io.sv ====
// host command port top: two framed channels, register, reply and download blocks
// strobe to reply or write is two clk_sys cycles

`timescale 1ns/1ps
`include "hps_settings.svh"

module hps_io
	import hps_cmd_pkg::*;
	import hps_core_pkg::*;
(
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      io_enable,
	input  logic                      fp_enable,
	input  logic                      io_strobe,
	input  logic [`HPS_WORD_W-1:0]   io_din,
	input  logic                      status_set,
	input  logic [`HPS_STATUS_W-1:0] status_in,
	input  logic [`HPS_WORD_W-1:0]   status_menumask,
	input  logic [`HPS_BYTE_W-1:0]   cfg_dout,
	input  logic                      ioctl_wait,
	output logic [`HPS_WORD_W-1:0]   io_dout,
	output logic [`HPS_WCNT_W-1:0]   cfg_addr,
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output logic [`HPS_JOY_W-1:0]    joystick_0,
	output logic [`HPS_JOY_W-1:0]    joystick_1,
	output logic [`HPS_STATUS_W-1:0] status,
	output logic                      ioctl_download,
	output logic                      ioctl_wr,
	output logic [`HPS_WORD_W-1:0]   ioctl_index,
	output logic [`HPS_IOADDR_W-1:0] ioctl_addr,
	output logic [`HPS_BYTE_W-1:0]   ioctl_dout,
	output logic                      hps_wait
);

	hps_word_t  io_word;
	hps_word_t  fp_word;
	hps_cfg_t   cfg;
	hps_stset_t stset;
	ioctl_t     ioctl;

	//////////////////////////////////////////////////
	// channel framing
	//////////////////////////////////////////////////

	hps_cmd_decode io_dec (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.frame_en  (io_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (io_word)
	);

	hps_cmd_decode fp_dec (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.frame_en  (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.word      (fp_word)
	);

	//////////////////////////////////////////////////
	// command execution
	//////////////////////////////////////////////////

	hps_user_regs u_user_regs (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.word       (io_word),
		.status_set (status_set),
		.status_in  (status_in),
		.cfg        (cfg),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.stset      (stset)
	);

	hps_reply_mux u_reply_mux (
		.clk_sys         (clk_sys),
		.rst             (rst),
		.word            (io_word),
		.stset           (stset),
		.status_menumask (status_menumask),
		.cfg_dout        (cfg_dout),
		.io_dout         (io_dout)
	);

	hps_file_loader u_file_loader (
		.clk_sys (clk_sys),
		.rst     (rst),
		.word    (fp_word),
		.ioctl   (ioctl)
	);

	// config string is addressed by the current word number
	assign cfg_addr = io_word.index;

	assign buttons            = cfg.buttons;
	assign forced_scandoubler = cfg.forced_scandoubler;
	assign direct_video       = cfg.direct_video;

	assign ioctl_download = ioctl.download;
	assign ioctl_wr       = ioctl.wr;
	assign ioctl_index    = ioctl.index;
	assign ioctl_addr     = ioctl.addr;
	assign ioctl_dout     = ioctl.dout;

	// only back-pressure toward the host
	assign hps_wait = ioctl_wait;

endmodule

// ==== testbench/tb_hps_host.svh ====
// host bus tasks and directed tests for the testbench top
// every task starts and returns just after a falling clk_sys edge

task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
	check_count++;
	assert (got === exp) else begin
		$display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		error_count++;
	end
endtask

task automatic check_true(input logic cond, input string what);
	check_count++;
	assert (cond) else begin
		$display("ERROR at %0d ns: %s", $time, what);
		error_count++;
	end
endtask

task automatic finish_test(input string name, input int errors_before);
	test_count++;
	$display("test %s done, %0d errors", name, error_count - errors_before);
endtask

//////////////////////////////////////////////////
// host bus
//////////////////////////////////////////////////

task automatic open_frame(input logic file_channel);
	if (file_channel) begin
		fp_enable = 1'b1;
	end else begin
		io_enable = 1'b1;
	end
	@(negedge clk_sys);
endtask

task automatic close_frame();
	io_enable = 1'b0;
	fp_enable = 1'b0;
	repeat (3) @(negedge clk_sys);
endtask

// one strobe sampled by the next rising edge
task automatic strobe_word(input logic [15:0] w);
	io_din    = w;
	io_strobe = 1'b1;
	@(negedge clk_sys);
	io_strobe = 1'b0;
endtask

task automatic send_word(input logic [15:0] w);
	strobe_word(w);
	repeat (4) @(negedge clk_sys);
endtask

// reply is on io_dout two cycles after the strobe
task automatic read_word(input logic [15:0] w, output logic [15:0] r);
	strobe_word(w);
	repeat (2) @(negedge clk_sys);
	r = io_dout;
	repeat (2) @(negedge clk_sys);
endtask

// hps_wait is sampled on rising edges away from the falling-edge drive
task automatic wait_host_ready(output int waited);
	logic busy;
	waited = 0;
	busy   = 1'b1;
	while (busy && waited < 50) begin
		@(posedge clk_sys);
		busy = hps_wait;
		@(negedge clk_sys);
		if (busy) begin
			waited++;
		end
	end
	check_true(!busy, "hps_wait stayed high, host could not strobe");
endtask

task automatic wait_write_pulse();
	int n;
	n = 0;
	while (!ioctl_wr && n < 8) begin
		@(negedge clk_sys);
		n++;
	end
	check_true(ioctl_wr, "no ioctl_wr pulse after a download data word");
endtask

//////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////

task automatic check_reset_values();
	int e;
	e = error_count;
	check_eq("io_dout", 64'(io_dout), 64'd0);
	check_eq("ioctl_download", 64'(ioctl_download), 64'd0);
	check_eq("ioctl_wr", 64'(ioctl_wr), 64'd0);
	check_eq("status", status, 64'd0);
	check_eq("joystick_0", 64'(joystick_0), 64'd0);
	check_eq("joystick_1", 64'(joystick_1), 64'd0);
	finish_test("reset_values", e);
endtask

task automatic cfg_joy_write();
	logic [31:0] r;
	logic [3:0]  flags;
	logic [15:0] cfg_word;
	logic [31:0] joy0;
	logic [31:0] joy1;
	int          e;
	e = error_count;
	r = next_random();
	joy0 = next_random();
	joy1 = next_random();
	// first pass writes random fields, the second their inverse
	for (int pass = 0; pass < 2; pass++) begin
		flags = (pass == 0) ? r[3:0] : ~r[3:0];
		// buttons in 1:0, scandoubler in 4, direct video in 10
		cfg_word = {5'h00, flags[3], 5'h00, flags[2], 2'b00, flags[1:0]};
		open_frame(1'b0);
		send_word(CMD_CFG);
		send_word(cfg_word);
		close_frame();
		check_eq("buttons", 64'(buttons), 64'(flags[1:0]));
		check_eq("forced_scandoubler", 64'(forced_scandoubler), 64'(flags[2]));
		check_eq("direct_video", 64'(direct_video), 64'(flags[3]));
	end
	open_frame(1'b0);
	send_word(CMD_JOY0);
	send_word(joy0[15:0]);
	send_word(joy0[31:16]);
	close_frame();
	open_frame(1'b0);
	send_word(CMD_JOY1);
	send_word(joy1[15:0]);
	send_word(joy1[31:16]);
	close_frame();
	check_eq("joystick_0", 64'(joystick_0), 64'(joy0));
	check_eq("joystick_1", 64'(joystick_1), 64'(joy1));
	finish_test("cfg_joy", e);
endtask

task automatic status_write_and_request();
	logic [63:0] st;
	logic [63:0] captured;
	logic [15:0] reply;
	int          e;
	e = error_count;
	st[31:0]  = next_random();
	st[63:32] = next_random();
	open_frame(1'b0);
	send_word(CMD_STATUS);
	for (int i = 0; i < 4; i++) begin
		send_word(st[16*i +: 16]);
	end
	close_frame();
	check_eq("status", status, st);

	captured[31:0]  = next_random();
	captured[63:32] = next_random();
	status_in = captured;
	repeat (2) begin
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		repeat (2) @(negedge clk_sys);
	end
	// the reply must come from the captured copy
	status_in = ~captured;
	open_frame(1'b0);
	send_word(CMD_STSET);
	read_word(16'h0000, reply);
	check_eq("io_dout (stset count)", 64'(reply), 64'h00A2);
	for (int i = 0; i < 4; i++) begin
		read_word(16'h0000, reply);
		check_eq("io_dout (stset status)", 64'(reply), 64'(captured[16*i +: 16]));
	end
	close_frame();
	finish_test("status", e);
endtask

task automatic cfg_string_read();
	logic [15:0] reply;
	int          e;
	e = error_count;
	open_frame(1'b0);
	send_word(CMD_CFGSTR);
	for (int n = 1; n <= 12; n++) begin
		read_word(16'h0000, reply);
		check_eq("io_dout (cfg string)", 64'(reply), 64'({8'h00, 8'(n) ^ 8'h5A}));
	end
	close_frame();
	finish_test("cfg_string", e);
endtask

task automatic file_download();
	logic [31:0] r;
	logic [15:0] file_idx;
	logic [26:0] start;
	logic [26:0] exp_addr;
	logic [15:0] data;
	int          waited;
	int          e;
	e = error_count;
	r = next_random();
	file_idx = r[15:0];
	open_frame(1'b1);
	send_word(CMD_FILE_IDX);
	send_word(file_idx);
	close_frame();
	check_eq("ioctl_index", 64'(ioctl_index), 64'(file_idx));

	r = next_random();
	start = r[26:0];
	open_frame(1'b1);
	send_word(CMD_FILE_TX);
	send_word(16'h0001);
	send_word(start[15:0]);
	send_word({5'h00, start[26:16]});
	close_frame();
	check_eq("ioctl_download", 64'(ioctl_download), 64'd1);

	open_frame(1'b1);
	send_word(CMD_FILE_DAT);
	for (int n = 0; n < 8; n++) begin
		r = next_random();
		data = r[15:0];
		if (n == 3) begin
			// core stalls the host for a few cycles
			ioctl_wait = 1'b1;
			@(negedge clk_sys);
			check_eq("hps_wait", 64'(hps_wait), 64'd1);
			fork
				begin
					repeat (6) @(negedge clk_sys);
					ioctl_wait = 1'b0;
				end
			join_none
		end
		wait_host_ready(waited);
		if (n == 3) begin
			check_true(waited > 0, "host strobed while hps_wait was high");
		end
		strobe_word(data);
		wait_write_pulse();
		exp_addr = start + 27'(n);
		check_eq("ioctl_addr", 64'(ioctl_addr), 64'(exp_addr));
		check_eq("ioctl_dout", 64'(ioctl_dout), 64'(data[7:0]));
		@(negedge clk_sys);
		check_eq("ioctl_wr", 64'(ioctl_wr), 64'd0);
		@(negedge clk_sys);
	end
	close_frame();

	open_frame(1'b1);
	send_word(CMD_FILE_TX);
	send_word(16'h0000);
	close_frame();
	check_eq("ioctl_download", 64'(ioctl_download), 64'd0);
	finish_test("download", e);
endtask

task automatic menumask_read();
	logic [31:0] r;
	logic [15:0] reply;
	int          e;
	e = error_count;
	r = next_random();
	status_menumask = r[15:0];
	open_frame(1'b0);
	send_word(CMD_MENUMASK);
	read_word(16'h0000, reply);
	check_eq("io_dout (menu mask)", 64'(reply), 64'(r[15:0]));
	close_frame();
	check_eq("io_dout after close", 64'(io_dout), 64'd0);
	finish_test("menumask", e);
endtask

// ==== testbench/tb_hps_io.sv ====
// testbench top for the host command port: clock, reset, config ROM model and test order
// host bus tasks and the directed tests come from tb_hps_host.svh

`timescale 1ns/1ps
`include "hps_settings.svh"

module tb_hps_io
	import hps_cmd_pkg::*;
();

	logic                      clk_sys;
	logic                      rst;
	logic                      io_enable;
	logic                      fp_enable;
	logic                      io_strobe;
	logic [`HPS_WORD_W-1:0]   io_din;
	logic                      status_set;
	logic [`HPS_STATUS_W-1:0] status_in;
	logic [`HPS_WORD_W-1:0]   status_menumask;
	logic [`HPS_BYTE_W-1:0]   cfg_dout;
	logic                      ioctl_wait;
	logic [`HPS_WORD_W-1:0]   io_dout;
	logic [`HPS_WCNT_W-1:0]   cfg_addr;
	logic [1:0]                buttons;
	logic                      forced_scandoubler;
	logic                      direct_video;
	logic [`HPS_JOY_W-1:0]    joystick_0;
	logic [`HPS_JOY_W-1:0]    joystick_1;
	logic [`HPS_STATUS_W-1:0] status;
	logic                      ioctl_download;
	logic                      ioctl_wr;
	logic [`HPS_WORD_W-1:0]   ioctl_index;
	logic [`HPS_IOADDR_W-1:0] ioctl_addr;
	logic [`HPS_BYTE_W-1:0]   ioctl_dout;
	logic                      hps_wait;

	int          check_count;
	int          error_count;
	int          test_count;
	logic [31:0] lcg_state;

	// config string ROM, byte at each address is its low byte xor 0x5a
	function automatic logic [7:0] rom_byte(input logic [`HPS_WCNT_W-1:0] addr);
		return addr[7:0] ^ 8'h5A;
	endfunction

	// lcg for test data
	function logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	assign cfg_dout = rom_byte(cfg_addr);

	hps_io uut (.*);

	always #10 clk_sys = ~clk_sys;

	`include "tb_hps_host.svh"

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		clk_sys         = 1'b0;
		rst             = 1'b1;
		io_enable       = 1'b0;
		fp_enable       = 1'b0;
		io_strobe       = 1'b0;
		io_din          = '0;
		status_set      = 1'b0;
		status_in       = '0;
		status_menumask = '0;
		ioctl_wait      = 1'b0;
		lcg_state       = 32'hb053;
		check_count     = 0;
		error_count     = 0;
		test_count      = 0;

		// three rising edges in reset
		repeat (3) @(negedge clk_sys);
		rst = 1'b0;

		check_reset_values();
		cfg_joy_write();
		status_write_and_request();
		cfg_string_read();
		file_download();
		menumask_read();

		$display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
+incdir+testbench
rtl/hps_cmd_pkg.sv
rtl/hps_core_pkg.sv
rtl/hps_cmd_decode.sv
rtl/hps_user_regs.sv
rtl/hps_file_loader.sv
rtl/hps_reply_mux.sv
rtl/hps_io.sv
testbench/tb_hps_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile the host command port testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hps_io \
	--Mdir obj_dir -o tb_hps_io -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/tb_hps_io)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
